//--- sim.f
hdl/bpu_pkg.sv
hdl/kind_table.sv
hdl/direction_table.sv
hdl/target_buffer.sv
hdl/return_stack.sv
hdl/predictor.sv
testbench/predictor_sva.sv
testbench/predictor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module predictor_tb \
    -f sim.f -o predictor_sim > build.log 2>&1 \
    && ./obj_dir/predictor_sim > sim.log 2>&1

grep -q '^STATUS: PASS$' sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- testbench/predictor_tb.sv
`timescale 1ns/100ps
`default_nettype none

module predictor_tb
    import bpu_pkg::*;
;

    localparam int k_width   = 8;
    localparam int h_width   = 6;
    localparam int stack_len = 8;
    localparam pred_t reset_pred = '{npc: PC_RESET + 30'd1, kind: NOT_JUMP, taken: 1'b0};

    logic  clk;
    logic  rstn;
    logic  stall;
    logic  [29:0] pc;
    logic  update_en;
    upd_t  upd;
    pred_t pred;

    // reference model state
    kind_e              kind_m  [2**k_width];
    logic [1:0]         cnt_m   [2**k_width];
    logic               valid_m [2**h_width];
    logic [29-h_width:0] tag_m  [2**h_width];
    logic [29:0]        tgt_m   [2**h_width];
    logic [29:0]        stack_m [stack_len];
    logic [2:0]         ptr_m;
    pred_t              exp_pred;
    logic [31:0]        rng;
    int                 ret_seen;
    int                 hit_seen;

    predictor #(
        .k_width  (k_width),
        .h_width  (h_width),
        .stack_len(stack_len)
    ) predictor_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .pc       (pc),
        .update_en(update_en),
        .upd      (upd),
        .pred     (pred)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // two bases with equal low bits, so tags collide on the same index
    function automatic logic [29:0] pick_pc(input logic [31:0] r);
        return (r[4] ? 30'h0123_4500 : PC_RESET) + {26'd0, r[3:0]};
    endfunction

    function automatic kind_e kind_from(input logic [2:0] sel);
        case (sel)
            3'd0:    return NOT_JUMP;
            3'd1:    return DIRECT_JUMP;
            3'd2:    return DIRECT_JUMP;
            3'd3:    return RET;
            3'd4:    return RET;
            3'd5:    return INDIRECT_JUMP;
            3'd6:    return CALL;
            default: return JUMP;
        endcase
    endfunction

    task automatic init_model();
        for (int i = 0; i < 2**k_width; i++) begin
            kind_m[i] = NOT_JUMP;
            cnt_m[i]  = 2'b01;
        end
        for (int i = 0; i < 2**h_width; i++) begin
            valid_m[i] = 1'b0;
            tag_m[i]   = '0;
            tgt_m[i]   = '0;
        end
        for (int i = 0; i < stack_len; i++) begin
            stack_m[i] = '0;
        end
        ptr_m    = '0;
        exp_pred = reset_pred;
    endtask

    // one rising edge: prediction from old state, then training
    task automatic step_model();
        logic [k_width-1:0] ki;
        logic [h_width-1:0] hi;
        logic [k_width-1:0] wki;
        logic [h_width-1:0] whi;
        logic               hit_m;
        if (!stall) begin
            ki    = pc[k_width-1:0];
            hi    = pc[h_width-1:0];
            hit_m = valid_m[hi] && (tag_m[hi] == pc[29:h_width]);
            exp_pred.kind  = kind_m[ki];
            exp_pred.taken = (kind_m[ki] == DIRECT_JUMP) ? cnt_m[ki][1] : (kind_m[ki] != NOT_JUMP);
            exp_pred.npc   = pc + 30'd1;
            if (kind_m[ki] == RET) begin
                exp_pred.npc = stack_m[ptr_m - 3'd1];
                ret_seen++;
            end else if (kind_m[ki] != NOT_JUMP && hit_m && exp_pred.taken) begin
                exp_pred.npc = tgt_m[hi];
                hit_seen++;
            end
            if (update_en) begin
                wki = upd.pc[k_width-1:0];
                whi = upd.pc[h_width-1:0];
                kind_m[wki] = upd.kind;
                if (upd.kind == DIRECT_JUMP) begin
                    if (upd.taken && cnt_m[wki] != 2'b11) cnt_m[wki] = cnt_m[wki] + 2'd1;
                    if (!upd.taken && cnt_m[wki] != 2'b00) cnt_m[wki] = cnt_m[wki] - 2'd1;
                end
                if (upd.taken && upd.kind != NOT_JUMP && upd.kind != RET) begin
                    valid_m[whi] = 1'b1;
                    tag_m[whi]   = upd.pc[29:h_width];
                    tgt_m[whi]   = upd.npc;
                end
                if (upd.kind == CALL) begin
                    stack_m[ptr_m] = upd.ret_pc;
                    ptr_m          = ptr_m + 3'd1; // wraps at stack_len
                end else if (upd.kind == RET) begin
                    ptr_m = ptr_m - 3'd1;
                end
            end
        end
    endtask

    task automatic drive_inputs();
        rng   = xorshift32(rng);
        stall = (rng[2:0] == 3'd0);
        rng   = xorshift32(rng);
        pc    = pick_pc(rng);
        rng   = xorshift32(rng);
        update_en = rng[0];
        upd.kind  = kind_from(rng[3:1]);
        upd.taken = rng[4];
        upd.pc    = pick_pc({8'd0, rng[31:8]});
        rng   = xorshift32(rng);
        upd.npc = pick_pc(rng);
        rng   = xorshift32(rng);
        upd.ret_pc = rng[29:0];
    endtask

    task automatic check_pred();
        assert (pred.npc === exp_pred.npc) else begin
            $display("Error: pred.npc = %h, expected %h", pred.npc, exp_pred.npc);
            $display("STATUS: FAIL");
            $fatal(1, "next address mismatch");
        end
        assert (pred.kind === exp_pred.kind) else begin
            $display("Error: pred.kind = %h, expected %h", pred.kind, exp_pred.kind);
            $display("STATUS: FAIL");
            $fatal(1, "kind mismatch");
        end
        assert (pred.taken === exp_pred.taken) else begin
            $display("Error: pred.taken = %h, expected %h", pred.taken, exp_pred.taken);
            $display("STATUS: FAIL");
            $fatal(1, "taken mismatch");
        end
    endtask

    initial begin
        int waited;
        rstn      = 1'b0;
        stall     = 1'b0;
        pc        = PC_RESET;
        update_en = 1'b0;
        upd       = '0;
        rng       = 32'he228_ccff;
        ret_seen  = 0;
        hit_seen  = 0;
        waited    = 0;
        init_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        while (pred !== reset_pred) begin // bounded wait for the reset prediction
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                $display("reset prediction never appeared on pred after reset");
                $display("STATUS: FAIL");
                $fatal(1, "reset timeout");
            end
        end
        for (int cyc = 0; cyc < 4000; cyc++) begin
            @(negedge clk);
            check_pred();
            drive_inputs();
            @(posedge clk);
            step_model();
        end
        @(negedge clk);
        check_pred();
        if (ret_seen == 0 || hit_seen == 0) begin
            $display("random stimulus never predicted a return or a target buffer hit");
            $display("STATUS: FAIL");
            $fatal(1, "stimulus too weak");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/predictor_sva.sv
`timescale 1ns/100ps
`default_nettype none

module predictor_sva
    import bpu_pkg::*;
(
    input wire logic        clk,
    input wire logic        rstn,
    input wire logic        stall,
    input wire logic [29:0] pc,
    input wire pred_t       pred
);

    // stall freezes pc_reg and every table read
    hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(pred))
        else $error("pred changed across a stalled cycle");

    // fall-through comes from the pc sampled one edge earlier
    not_jump_untaken: assert property (@(posedge clk)
        $past(rstn) && !$past(stall) && (pred.kind == NOT_JUMP)
            |-> (!pred.taken && pred.npc == $past(pc) + 30'd1))
        else $error("NOT_JUMP prediction is taken or does not point at pc plus one");

    reset_value: assert property (@(posedge clk)
        !rstn |=> (pred.npc == PC_RESET + 30'd1 && pred.kind == NOT_JUMP && !pred.taken))
        else $error("pred after reset is not the reset prediction");

endmodule

bind predictor predictor_sva predictor_sva_inst (
    .clk  (clk),
    .rstn (rstn),
    .stall(stall),
    .pc   (pc),
    .pred (pred)
);

`default_nettype wire

//--- hdl/predictor.sv
`timescale 1ns/100ps
`default_nettype none

module predictor
    import bpu_pkg::*;
#(
    parameter int k_width   = 8,
    parameter int h_width   = 6,
    parameter int stack_len = 8
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        stall,
    input  wire logic [29:0] pc,
    input  wire logic        update_en,
    input  wire upd_t        upd,
    output pred_t            pred
);

    logic [29:0] pc_reg;
    logic [29:0] seq_pc;
    kind_e       kind;
    logic        cnt_taken;
    logic        hit;
    logic [29:0] target;
    logic [29:0] top;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= PC_RESET;
        end else if (!stall) begin
            pc_reg <= pc;
        end
    end

    assign seq_pc = pc_reg + 30'd1;

    kind_table #(
        .k_width(k_width)
    ) kind_table_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .pc       (pc),
        .update_en(update_en),
        .upd      (upd),
        .kind     (kind)
    );

    direction_table #(
        .k_width(k_width)
    ) direction_table_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .pc       (pc),
        .update_en(update_en),
        .upd      (upd),
        .cnt_taken(cnt_taken)
    );

    target_buffer #(
        .h_width(h_width)
    ) target_buffer_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .pc       (pc),
        .update_en(update_en),
        .upd      (upd),
        .hit      (hit),
        .target   (target)
    );

    return_stack #(
        .stack_len(stack_len)
    ) return_stack_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .update_en(update_en),
        .upd      (upd),
        .top      (top)
    );

    // next address select
    always_comb begin
        pred.kind  = kind;
        pred.taken = 1'b1;
        pred.npc   = seq_pc;
        case (kind)
            NOT_JUMP: begin
                pred.taken = 1'b0;
            end
            DIRECT_JUMP: begin
                pred.taken = cnt_taken;
                if (cnt_taken && hit) begin
                    pred.npc = target;
                end
            end
            RET: begin
                pred.npc = top;
            end
            default: begin // jump, call, indirect
                if (hit) begin
                    pred.npc = target;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/return_stack.sv
`timescale 1ns/100ps
`default_nettype none

module return_stack
    import bpu_pkg::*;
#(
    parameter int stack_len = 8 // power of two
) (
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic   stall,
    input  wire logic   update_en,
    input  wire upd_t   upd,
    output logic [29:0] top
);

    localparam int ptr_w = $clog2(stack_len);

    logic [29:0]      stack [stack_len];
    logic [ptr_w-1:0] ptr;     // next free slot
    logic [ptr_w-1:0] top_idx;
    logic             push;
    logic             pop;

    assign top_idx = ptr - 1'b1; // wraps below zero
    assign push    = update_en && (upd.kind == CALL);
    assign pop     = update_en && (upd.kind == RET);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr <= '0;
            top <= '0;
            for (int i = 0; i < stack_len; i++) begin
                stack[i] <= '0;
            end
        end else if (!stall) begin
            top <= stack[top_idx];
            if (push) begin
                stack[ptr] <= upd.ret_pc;
                ptr        <= ptr + 1'b1;
            end else if (pop) begin
                ptr <= ptr - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module target_buffer
    import bpu_pkg::*;
#(
    parameter int h_width = 6
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        stall,
    input  wire logic [29:0] pc,
    input  wire logic        update_en,
    input  wire upd_t        upd,
    output logic             hit,
    output logic [29:0]      target
);

    localparam int depth = 2 ** h_width;
    localparam int tag_w = 30 - h_width;

    logic [depth-1:0]   valid;
    logic [tag_w-1:0]   tags [depth];
    logic [29:0]        tgts [depth];

    logic [h_width-1:0] rd_idx;
    logic [tag_w-1:0]   rd_tag;
    logic [h_width-1:0] wr_idx;
    logic [tag_w-1:0]   wr_tag;
    logic               alloc;

    assign rd_idx = pc[h_width-1:0];
    assign rd_tag = pc[29:h_width];
    assign wr_idx = upd.pc[h_width-1:0];
    assign wr_tag = upd.pc[29:h_width];

    // returns go through the stack, not the buffer
    assign alloc = update_en && upd.taken &&
                   (upd.kind != NOT_JUMP) && (upd.kind != RET);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            hit   <= 1'b0;
        end else if (!stall) begin
            hit <= valid[rd_idx] && (tags[rd_idx] == rd_tag);
            if (alloc) begin
                valid[wr_idx] <= 1'b1;
            end
        end
    end

    // tag and target arrays, no reset
    always_ff @(posedge clk) begin
        if (!stall) begin
            target <= tgts[rd_idx];
            if (alloc) begin
                tags[wr_idx] <= wr_tag;
                tgts[wr_idx] <= upd.npc;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/direction_table.sv
`timescale 1ns/100ps
`default_nettype none

module direction_table
    import bpu_pkg::*;
#(
    parameter int k_width = 8
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        stall,
    input  wire logic [29:0] pc,
    input  wire logic        update_en,
    input  wire upd_t        upd,
    output logic             cnt_taken
);

    localparam int depth = 2 ** k_width;

    logic [1:0]         cnt [depth];
    logic [k_width-1:0] rd_idx;
    logic [k_width-1:0] wr_idx;
    logic [1:0]         old_cnt;
    logic               train;

    assign rd_idx  = pc[k_width-1:0];
    assign wr_idx  = upd.pc[k_width-1:0];
    assign old_cnt = cnt[wr_idx];
    // only conditional branches move the counters
    assign train   = update_en && (upd.kind == DIRECT_JUMP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt_taken <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                cnt[i] <= 2'b01; // weakly not taken
            end
        end else if (!stall) begin
            cnt_taken <= cnt[rd_idx][1];
            if (train) begin
                if (upd.taken && old_cnt != 2'b11) begin
                    cnt[wr_idx] <= old_cnt + 2'd1;
                end else if (!upd.taken && old_cnt != 2'b00) begin
                    cnt[wr_idx] <= old_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/kind_table.sv
`timescale 1ns/100ps
`default_nettype none

module kind_table
    import bpu_pkg::*;
#(
    parameter int k_width = 8
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        stall,
    input  wire logic [29:0] pc,
    input  wire logic        update_en,
    input  wire upd_t        upd,
    output kind_e            kind
);

    localparam int depth = 2 ** k_width;

    kind_e            mem [depth];
    logic [k_width-1:0] rd_idx;
    logic [k_width-1:0] wr_idx;

    assign rd_idx = pc[k_width-1:0];
    assign wr_idx = upd.pc[k_width-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            kind <= NOT_JUMP;
            for (int i = 0; i < depth; i++) begin
                mem[i] <= NOT_JUMP;
            end
        end else if (!stall) begin
            kind <= mem[rd_idx]; // old value on a same-index write
            if (update_en) begin
                mem[wr_idx] <= upd.kind;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // instruction kinds as resolved by the execute stage
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1, // conditional branch
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } kind_e;

    // word address of the first fetch
    localparam logic [29:0] PC_RESET = 30'h0700_0000;

    // fetch side prediction, 34 bits
    typedef struct packed {
        logic [29:0] npc;
        kind_e       kind;
        logic        taken;
    } pred_t;

    // training word from execute, 94 bits
    typedef struct packed {
        logic [29:0] pc;
        logic [29:0] npc;
        logic [29:0] ret_pc; // only meaningful for calls
        kind_e       kind;
        logic        taken;
    } upd_t;

endpackage

`default_nettype wire
